//--- rtl/aes_pkg.sv
// Shared definitions for the pipelined AES-192 encryption core.
// Holds the data widths, the key-step struct and enum, the latency
// constants and the GF(2^8) arithmetic used by the round logic.

`default_nettype none

package aes_pkg;

    typedef logic [7:0]   byte_t;    // one state or key byte
    typedef logic [31:0]  word_t;    // one column / schedule word
    typedef logic [127:0] block_t;   // state or round key
    typedef logic [191:0] key192_t;  // six-word key window
    typedef logic [4:0]   count_t;   // valid countdown

    // outputs of one key-schedule step
    typedef struct packed {
        key192_t next_key;   // window for the following step
        block_t  round_key;  // key for the matching round
    } key_pair_t;

    // schedule step kinds; d opens the chain, then b, a, c repeat
    typedef enum logic [1:0] {
        step_d,
        step_a,
        step_b,
        step_c
    } step_kind_t;

    localparam int NUM_ROUNDS   = 11;  // full rounds before the final one
    localparam int CORE_LATENCY = 25;  // start edge to out_valid

    // multiply by x, reduced by the AES polynomial
    function automatic byte_t gf_mul2(input byte_t x);
        byte_t shifted;
        shifted = {x[6:0], 1'b0};
        if (x[7])
            shifted = shifted ^ 8'h1b;
        return shifted;
    endfunction

    // shift-and-add multiply in GF(2^8)
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t x;
        acc = '0;
        x   = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ x;
            x = gf_mul2(x);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

//--- rtl/aes_sbox_word.sv
// Registered AES S-box for the four bytes of one 32-bit word.
// Each byte is inverted in GF(2^8) by an exponent chain, then run
// through the affine transform; the result is registered.

`default_nettype none

module aes_sbox_word (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire aes_pkg::word_t din,
    output aes_pkg::word_t      dout
);

    aes_pkg::word_t sub_comb;

    // x^254 is the inverse for nonzero x, and maps zero to zero
    function automatic aes_pkg::byte_t sub_byte(input aes_pkg::byte_t x);
        aes_pkg::byte_t p;
        aes_pkg::byte_t inv;
        p = x;
        // p runs through x^3, x^7, ... x^127
        for (int i = 0; i < 6; i++)
        begin
            p = aes_pkg::gf_mul(aes_pkg::gf_mul(p, p), x);
        end
        inv = aes_pkg::gf_mul(p, p);  // x^254
        return inv
            ^ {inv[6:0], inv[7]}       // rotl 1
            ^ {inv[5:0], inv[7:6]}     // rotl 2
            ^ {inv[4:0], inv[7:5]}     // rotl 3
            ^ {inv[3:0], inv[7:4]}     // rotl 4
            ^ 8'h63;
    endfunction

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            sub_comb[8*i +: 8] = sub_byte(din[8*i +: 8]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            dout <= '0;
        else
            dout <= sub_comb;
    end

endmodule

`default_nettype wire

//--- rtl/aes_round.sv
// One registered AES cipher round.
// Stage 1 is the byte substitution (four registered S-box words),
// stage 2 the row shift, the optional column mix and the key add.
// The final round is selected by last_round and skips the column mix.

`default_nettype none

module aes_round #(
    parameter bit last_round = 1'b0
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire aes_pkg::block_t state_in,
    input  wire aes_pkg::block_t round_key,  // arrives one cycle after state_in
    output aes_pkg::block_t      state_out
);

    aes_pkg::word_t  sub_w [4];
    aes_pkg::block_t sub_blk;
    aes_pkg::block_t shifted;
    aes_pkg::block_t mixed;

    // MixColumns on one column, 3a = 2a ^ a
    function automatic aes_pkg::word_t mix_column(input aes_pkg::word_t w);
        aes_pkg::byte_t a0, a1, a2, a3;
        aes_pkg::byte_t d0, d1, d2, d3;
        {a0, a1, a2, a3} = w;
        d0 = aes_pkg::gf_mul2(a0);
        d1 = aes_pkg::gf_mul2(a1);
        d2 = aes_pkg::gf_mul2(a2);
        d3 = aes_pkg::gf_mul2(a3);
        return {d0 ^ d1 ^ a1 ^ a2 ^ a3,
                a0 ^ d1 ^ d2 ^ a2 ^ a3,
                a0 ^ a1 ^ d2 ^ d3 ^ a3,
                d0 ^ a0 ^ a1 ^ a2 ^ d3};
    endfunction

    // one S-box word per state column
    for (genvar c = 0; c < 4; c++)
    begin : g_sbox
        aes_sbox_word u_sbox (
            .clk  (clk),
            .rst  (rst),
            .din  (state_in[127 - 32*c -: 32]),
            .dout (sub_w[c])
        );
    end

    assign sub_blk = {sub_w[0], sub_w[1], sub_w[2], sub_w[3]};

    // row r rotates left by r columns; byte n = 4*col + row
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[127 - 8*(4*c + r) -: 8] = sub_blk[127 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
    end

    always_comb
    begin
        mixed = shifted;
        if (!last_round)
        begin
            for (int c = 0; c < 4; c++)
            begin
                mixed[127 - 32*c -: 32] = mix_column(shifted[127 - 32*c -: 32]);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state_out <= '0;
        else
            state_out <= mixed ^ round_key;  // key add
    end

endmodule

`default_nettype wire

//--- rtl/aes_key_step_192.sv
// One registered step of the AES-192 key schedule.
// The step kind picks which window words are updated, whether the
// S-box path is used, and which four words form the round key.
// round_key is valid one cycle after key_in, next_key after two.

`default_nettype none

module aes_key_step_192 #(
    parameter aes_pkg::step_kind_t kind = aes_pkg::step_a
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire aes_pkg::key192_t key_in,
    input  wire aes_pkg::byte_t   rcon,    // unused by kind b
    output aes_pkg::key_pair_t    keys
);

    aes_pkg::word_t    k [6];     // input window words, word 0 on top
    aes_pkg::word_t    v [6];     // xor chain before the sbox term
    aes_pkg::word_t    w [6];     // stage 1 register
    aes_pkg::word_t    b [6];     // stage 1 with the sbox term folded in
    aes_pkg::word_t    sub_in;
    aes_pkg::word_t    sub_out;
    aes_pkg::block_t   rk;
    aes_pkg::key192_t  next_r;

    always_comb
    begin
        for (int i = 0; i < 6; i++)
        begin
            k[i] = key_in[191 - 32*i -: 32];
        end
        v = k;
        case (kind)
            aes_pkg::step_a:
            begin
                v[0] = {k[0][31:24] ^ rcon, k[0][23:0]};
                v[1] = v[0] ^ k[1];
                v[2] = v[1] ^ k[2];
                v[3] = v[2] ^ k[3];
            end
            aes_pkg::step_b:
            begin
                v[2] = k[1] ^ k[2];
                v[3] = v[2] ^ k[3];
                v[4] = v[3] ^ k[4];
                v[5] = v[4] ^ k[5];
            end
            aes_pkg::step_c:
            begin
                v[0] = {k[0][31:24] ^ rcon, k[0][23:0]};
                v[1] = v[0] ^ k[1];
                v[4] = k[3] ^ k[4];
                v[5] = v[4] ^ k[5];
            end
            default:
            begin
                v[0] = {k[0][31:24] ^ rcon, k[0][23:0]};
                v[1] = v[0] ^ k[1];
            end
        endcase
    end

    // kind c substitutes its freshly made last word
    assign sub_in = (kind == aes_pkg::step_c) ? {v[5][23:0], v[5][31:24]}
                                              : {k[5][23:0], k[5][31:24]};

    if (kind != aes_pkg::step_b)
    begin : g_sub
        aes_sbox_word u_sbox (
            .clk  (clk),
            .rst  (rst),
            .din  (sub_in),
            .dout (sub_out)
        );
    end
    else
    begin : g_no_sub
        assign sub_out = '0;  // plain xor step
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 6; i++)
            begin
                w[i] <= '0;
            end
        end
        else
            w <= v;
    end

    always_comb
    begin
        b = w;
        case (kind)
            aes_pkg::step_a:
            begin
                for (int i = 0; i < 4; i++)
                begin
                    b[i] = w[i] ^ sub_out;
                end
            end
            aes_pkg::step_b: ;
            default:
            begin
                b[0] = w[0] ^ sub_out;
                b[1] = w[1] ^ sub_out;
            end
        endcase
        case (kind)
            aes_pkg::step_a: rk = {b[0], b[1], b[2], b[3]};
            aes_pkg::step_b: rk = {b[2], b[3], b[4], b[5]};
            default:         rk = {b[4], b[5], b[0], b[1]};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            next_r <= '0;
        else
            next_r <= {b[0], b[1], b[2], b[3], b[4], b[5]};
    end

    assign keys = '{next_key: next_r, round_key: rk};

endmodule

`default_nettype wire

//--- rtl/aes_192.sv
// Top level of the fully unrolled AES-192 encryption pipeline.
// Contains the start-edge detect, the initial key add, the chain of
// twelve key-schedule steps, the twelve rounds and the valid counter.

`default_nettype none

module aes_192 (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,
    input  wire aes_pkg::block_t  state,
    input  wire aes_pkg::key192_t key,
    output aes_pkg::block_t       out,
    output logic                  out_valid
);

    logic               start_r;
    logic               start_edge;
    aes_pkg::count_t    valid_cnt;
    aes_pkg::block_t    s0;
    aes_pkg::key192_t   k0;
    aes_pkg::block_t    st [aes_pkg::NUM_ROUNDS + 2];  // st[i] feeds round i
    aes_pkg::key_pair_t kp [aes_pkg::NUM_ROUNDS + 1];

    assign start_edge = start & ~start_r;

    always_ff @(posedge clk)
    begin
        if (rst)
            start_r <= 1'b0;
        else
            start_r <= start;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s0        <= '0;
            k0        <= '0;
            valid_cnt <= '0;
        end
        else if (start_edge)
        begin
            s0        <= state ^ key[191:64];  // round key 0 is words 0..3
            k0        <= key;
            valid_cnt <= aes_pkg::count_t'(aes_pkg::CORE_LATENCY + 1);
        end
        else if (valid_cnt > aes_pkg::count_t'(1))
            valid_cnt <= valid_cnt - 1'b1;  // parks at 1
    end

    assign out_valid = (valid_cnt == aes_pkg::count_t'(1));

    // key schedule chain, kinds d b a c b a c b a c b a
    aes_key_step_192 #(.kind(aes_pkg::step_d)) u_ks0 (.clk(clk), .rst(rst),
        .key_in(k0), .rcon(8'h01), .keys(kp[0]));
    aes_key_step_192 #(.kind(aes_pkg::step_b)) u_ks1 (.clk(clk), .rst(rst),
        .key_in(kp[0].next_key), .rcon(8'h00), .keys(kp[1]));
    aes_key_step_192 #(.kind(aes_pkg::step_a)) u_ks2 (.clk(clk), .rst(rst),
        .key_in(kp[1].next_key), .rcon(8'h02), .keys(kp[2]));
    aes_key_step_192 #(.kind(aes_pkg::step_c)) u_ks3 (.clk(clk), .rst(rst),
        .key_in(kp[2].next_key), .rcon(8'h04), .keys(kp[3]));
    aes_key_step_192 #(.kind(aes_pkg::step_b)) u_ks4 (.clk(clk), .rst(rst),
        .key_in(kp[3].next_key), .rcon(8'h00), .keys(kp[4]));
    aes_key_step_192 #(.kind(aes_pkg::step_a)) u_ks5 (.clk(clk), .rst(rst),
        .key_in(kp[4].next_key), .rcon(8'h08), .keys(kp[5]));
    aes_key_step_192 #(.kind(aes_pkg::step_c)) u_ks6 (.clk(clk), .rst(rst),
        .key_in(kp[5].next_key), .rcon(8'h10), .keys(kp[6]));
    aes_key_step_192 #(.kind(aes_pkg::step_b)) u_ks7 (.clk(clk), .rst(rst),
        .key_in(kp[6].next_key), .rcon(8'h00), .keys(kp[7]));
    aes_key_step_192 #(.kind(aes_pkg::step_a)) u_ks8 (.clk(clk), .rst(rst),
        .key_in(kp[7].next_key), .rcon(8'h20), .keys(kp[8]));
    aes_key_step_192 #(.kind(aes_pkg::step_c)) u_ks9 (.clk(clk), .rst(rst),
        .key_in(kp[8].next_key), .rcon(8'h40), .keys(kp[9]));
    aes_key_step_192 #(.kind(aes_pkg::step_b)) u_ks10 (.clk(clk), .rst(rst),
        .key_in(kp[9].next_key), .rcon(8'h00), .keys(kp[10]));
    aes_key_step_192 #(.kind(aes_pkg::step_a)) u_ks11 (.clk(clk), .rst(rst),
        .key_in(kp[10].next_key), .rcon(8'h80), .keys(kp[11]));

    assign st[0] = s0;

    // full rounds, then the final round without column mix
    for (genvar i = 0; i <= aes_pkg::NUM_ROUNDS; i++)
    begin : g_round
        aes_round #(
            .last_round (i == aes_pkg::NUM_ROUNDS)
        ) u_round (
            .clk       (clk),
            .rst       (rst),
            .state_in  (st[i]),
            .round_key (kp[i].round_key),
            .state_out (st[i + 1])
        );
    end

    assign out = st[aes_pkg::NUM_ROUNDS + 1];

endmodule

`default_nettype wire

//--- dv/aes_192_tb.sv
// Self-checking testbench for the AES-192 pipeline.
// Reads key, plaintext, expected ciphertext and restart gap per vector,
// drives start edges of random length and checks out and out_valid.
// Includes a watchdog sized from the number of vectors.

`default_nettype none

module aes_192_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VECTORS     = 9;
    localparam int WORDS_PER_VEC   = 4;  // key, plaintext, ciphertext, gap
    localparam int STABLE_CYCLES   = 4;
    localparam int DRIVE_DELAY     = 2;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * (aes_pkg::CORE_LATENCY + 10) + 50;

    logic             clk;
    logic             rst;
    logic             start;
    aes_pkg::block_t  state;
    aes_pkg::key192_t key;
    aes_pkg::block_t  out;
    logic             out_valid;

    logic [191:0] vec_mem [WORDS_PER_VEC * NUM_VECTORS];

    aes_192 u_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .state     (state),
        .key       (key),
        .out       (out),
        .out_valid (out_valid)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_block(input string name, input aes_pkg::block_t actual,
                               input aes_pkg::block_t expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_valid(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // outputs settled, inputs safe to change
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // a nonzero next_gap puts the following start edge next_gap cycles after this one
    // so this block is never marked valid
    task automatic run_vector(input int idx, input int hold, input int next_gap);
        aes_pkg::block_t expected;
        int              k;
        bit              done;
        key      = vec_mem[WORDS_PER_VEC*idx];
        state    = vec_mem[WORDS_PER_VEC*idx + 1][127:0];
        expected = vec_mem[WORDS_PER_VEC*idx + 2][127:0];
        start    = 1'b1;
        k        = -1;
        done     = 1'b0;
        while (!done)
        begin
            next_cycle();
            k++;  // cycles since the sampled edge
            if (k == 0)
            begin
                state = ~state;  // only the edge cycle's block may be encrypted
                key   = ~key;
            end
            if (k == hold - 1)
                start = 1'b0;
            if (next_gap > 0)
            begin
                check_valid("out_valid", out_valid, 1'b0);
                done = (k == next_gap - 1);  // next launch sampled on the following edge
            end
            else
            begin
                check_valid("out_valid", out_valid, k == aes_pkg::CORE_LATENCY);
                if (out_valid)
                begin
                    check_block("out", out, expected);
                    done = 1'b1;
                end
            end
        end
        if (next_gap == 0)
        begin
            // result held until the next start
            for (int s = 0; s < STABLE_CYCLES; s++)
            begin
                next_cycle();
                check_valid("out_valid", out_valid, 1'b1);
                check_block("out", out, expected);
            end
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial
    begin
        int hold;
        int next_gap;
        void'($urandom(32'h2919553f));
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        state = '0;
        key   = '0;
        $readmemh("dv/aes_192_tests.txt", vec_mem);
        if ($isunknown(vec_mem[0]))
        begin
            $display("could not load test vectors from dv/aes_192_tests.txt");
            abort_run();
        end
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_valid("out_valid", out_valid, 1'b0);
        for (int i = 0; i < 6; i++)
        begin
            next_cycle();
            check_valid("out_valid", out_valid, 1'b0);  // idle, no start yet
        end
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            next_gap = 0;
            if (i + 1 < NUM_VECTORS)
                next_gap = int'(vec_mem[WORDS_PER_VEC*(i + 1) + 3][31:0]);
            if (next_gap == 1 || next_gap >= aes_pkg::CORE_LATENCY)
            begin
                $display("vector %0d has a restart gap of %0d, outside 2..%0d", i + 1,
                         next_gap, aes_pkg::CORE_LATENCY - 1);
                abort_run();
            end
            // the file opens with the FIPS-197 vector twice, short then long start
            if (i == 0)
                hold = 1;
            else if (i == 1)
                hold = 4;
            else
                hold = 1 + ($urandom % 4);
            if (next_gap > 0 && hold > next_gap - 1)
                hold = next_gap - 1;  // start must drop before the restart edge
            run_vector(i, hold, next_gap);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/aes_pkg.sv
rtl/aes_sbox_word.sv
rtl/aes_round.sv
rtl/aes_key_step_192.sv
rtl/aes_192.sv
dv/aes_192_tb.sv

//--- dv/aes_192_tests.txt
// columns: key (192 bits), plaintext, expected ciphertext, restart gap in cycles
// gap 0 waits for the previous result; gap n starts n cycles after the previous start
000102030405060708090a0b0c0d0e0f1011121314151617 00112233445566778899aabbccddeeff dda97ca4864cdfe06eaf70a0ec0d7191 0
000102030405060708090a0b0c0d0e0f1011121314151617 00112233445566778899aabbccddeeff dda97ca4864cdfe06eaf70a0ec0d7191 0
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b 6bc1bee22e409f96e93d7e117393172a bd334f1d6e45f25ff712a214571fa5cc 0
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b ae2d8a571e03ac9c9eb76fac45af8e51 974104846d0ad3ad7734ecb3ecee4eef 0
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b 30c81c46a35ce411e5fbc1191a0a52ef ef7afd2270e2e60adce0ba2face6444e 5
000000000000000000000000000000000000000000000000 00000000000000000000000000000000 aae06992acbf52a3e8f4a96ec9300bd7 0
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b f69f2445df4f9b17ad2b417be66c3710 9a4b41ba738d6c72fb16691603c18e0e 0
000102030405060708090a0b0c0d0e0f1011121314151617 00112233445566778899aabbccddeeff dda97ca4864cdfe06eaf70a0ec0d7191 18
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b 6bc1bee22e409f96e93d7e117393172a bd334f1d6e45f25ff712a214571fa5cc 2
